//--- logic/regbank_pkg.sv
package regbank_pkg;

   // bus geometry
   localparam int DATA_W = 32;          // bus data width
   localparam int STRB_W = DATA_W / 8;  // one strobe bit per byte lane
   localparam int REG_W = 8;            // one register per byte lane
   localparam int WADDR_W = 6;          // word address, up to 256 registers

   // lane position inside a word, and full register index
   localparam int LANE_W = $clog2(STRB_W);
   localparam int IDX_W = WADDR_W + LANE_W;

   // one bus write, address selects a group of STRB_W registers
   typedef struct packed {
      logic [WADDR_W-1:0] waddr;
      logic [STRB_W-1:0]  wstrb;  // bit j enables byte lane j
      logic [DATA_W-1:0]  wdata;
   } wr_req_t;

   // one bus read, always a whole word
   typedef struct packed {
      logic [WADDR_W-1:0] raddr;
   } rd_req_t;

endpackage

//--- logic/strobe_offset.sv
`timescale 1ns/1ps

module strobe_offset (
   input  logic [regbank_pkg::STRB_W-1:0] strb_i,
   output logic [regbank_pkg::LANE_W-1:0] offset_o,
   output logic                           none_o
);

   // trailing zero count, scanned from the top so the lowest set bit wins
   always_comb begin
      offset_o = '0;
      for (int i = regbank_pkg::STRB_W - 1; i >= 0; i--) begin
         if (strb_i[i]) begin
            offset_o = regbank_pkg::LANE_W'(i);
         end
      end
   end

   assign none_o = ~|strb_i;  // no lane active

   // offset must land on an active lane
   // strobe is unknown before the first registered write, so skip that
   always_comb begin
      if (!$isunknown(strb_i) && !none_o) begin
         a_offset_on_set_bit : assert (strb_i[offset_o])
            else $error("strobe_offset: offset %0d not set in %b", offset_o, strb_i);
      end
   end

endmodule

//--- logic/regfile_2p.sv
`timescale 1ns/1ps

module regfile_2p #(
   parameter int N = 32  // number of byte registers
) (
   input  logic                             clk_i,
   input  logic                             reset_i,
   input  logic                             cke_i,
   input  logic                             wen_i,
   input  regbank_pkg::wr_req_t             wr_req_i,
   input  regbank_pkg::rd_req_t             rd_req_i,
   output logic [regbank_pkg::DATA_W-1:0]   rd_word_o
);

   localparam int STRB_W = regbank_pkg::STRB_W;
   localparam int REG_W = regbank_pkg::REG_W;
   localparam int LANE_W = regbank_pkg::LANE_W;
   localparam int IDX_W = regbank_pkg::IDX_W;

   // words that hold at least one real register
   localparam int NWORDS = (N + STRB_W - 1) / STRB_W;

   logic [REG_W-1:0] regs [N];

   // per lane register index for the write and the read port
   logic [IDX_W-1:0] widx [STRB_W];
   logic [IDX_W-1:0] ridx [STRB_W];

   logic [N-1:0] wen;     // per register write enable
   logic [N-1:0] rd_hit;  // per register read select

   genvar j;
   genvar r;

   // word address plus lane position gives the register a lane maps to
   generate
      for (j = 0; j < STRB_W; j++) begin : g_lane
         assign widx[j] = {wr_req_i.waddr, LANE_W'(j)};
         assign ridx[j] = {rd_req_i.raddr, LANE_W'(j)};
      end
   endgenerate

   // register array
   // a lane index at or above N never matches, so those writes drop out
   generate
      for (r = 0; r < N; r++) begin : g_reg
         localparam int LANE = r % STRB_W;

         assign wen[r] = wen_i
                       & cke_i
                       & wr_req_i.wstrb[LANE]
                       & (widx[LANE] == IDX_W'(r));

         assign rd_hit[r] = (ridx[LANE] == IDX_W'(r));

         always_ff @(posedge clk_i) begin
            if (reset_i) begin
               regs[r] <= '0;
            end else if (wen[r]) begin
               regs[r] <= wr_req_i.wdata[LANE*REG_W +: REG_W];
            end
         end
      end
   endgenerate

   // read port, combinational
   // every lane starts at zero so indices past N come back empty
   always_comb begin
      rd_word_o = '0;
      for (int k = 0; k < N; k++) begin
         if (rd_hit[k]) begin
            rd_word_o[(k % STRB_W)*REG_W +: REG_W] = regs[k];
         end
      end
   end

   // strobe arrives one cycle after the bus write, from the access stage
   a_no_x_strobe : assert property (
      @(posedge clk_i) disable iff (reset_i)
      (wen_i && (wr_req_i.waddr < NWORDS)) |-> !$isunknown(wr_req_i.wstrb)
   ) else $error("regfile_2p: unknown strobe on write to word %0d", wr_req_i.waddr);

endmodule

//--- logic/csr_access.sv
`timescale 1ns/1ps

module csr_access #(
   parameter int N = 32  // number of byte registers behind this stage
) (
   input  logic                                clk_i,
   input  logic                                reset_i,
   input  logic                                wr_i,
   input  regbank_pkg::wr_req_t                wr_req_i,
   input  logic                                rd_i,
   input  regbank_pkg::rd_req_t                rd_req_i,
   output logic                                wen_o,
   output regbank_pkg::wr_req_t                wr_req_o,
   output regbank_pkg::rd_req_t                rd_req_o,
   input  logic [regbank_pkg::DATA_W-1:0]      rd_word_i,
   output logic [regbank_pkg::DATA_W-1:0]      rdata_o,
   output logic                                rvalid_o,
   output logic [regbank_pkg::IDX_W-1:0]       last_widx_o
);

   localparam int MAX_REGS = 1 << regbank_pkg::IDX_W;

   // index space of the status output must cover the array
   generate
      if (N < 1 || N > MAX_REGS) begin : g_bad_n
         $fatal(1, "csr_access: N=%0d outside 1..%0d", N, MAX_REGS);
      end
   endgenerate

   logic                               wen_q;
   regbank_pkg::wr_req_t               wr_req_q;
   logic [regbank_pkg::DATA_W-1:0]     rdata_q;
   logic                               rvalid_q;
   logic [regbank_pkg::IDX_W-1:0]      last_widx_q;

   logic [regbank_pkg::LANE_W-1:0]     lane_off;
   logic                               strb_none;

   // write path, one register stage
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wen_q <= 1'b0;
      end else begin
         wen_q <= wr_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_i) begin
         wr_req_q <= wr_req_i;  // payload only
      end
   end

   assign wen_o = wen_q;
   assign wr_req_o = wr_req_q;

   // first active lane of the registered write
   strobe_offset i_strobe_offset (
      .strb_i  (wr_req_q.wstrb),
      .offset_o(lane_off),
      .none_o  (strb_none)
   );

   // status follows the bus, not the clock enable
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         last_widx_q <= '0;
      end else if (wen_q && !strb_none) begin
         last_widx_q <= {wr_req_q.waddr, lane_off};  // word base plus lane
      end
   end

   assign last_widx_o = last_widx_q;

   // read path, address straight through, data caught at the next edge
   assign rd_req_o = rd_req_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rvalid_q <= 1'b0;
         rdata_q <= '0;
      end else begin
         rvalid_q <= rd_i;
         if (rd_i) begin
            rdata_q <= rd_word_i;
         end
      end
   end

   assign rdata_o = rdata_q;
   assign rvalid_o = rvalid_q;

   // one response per read, always the following cycle
   a_rvalid_timing : assert property (
      @(posedge clk_i) disable iff (reset_i)
      1'b1 |=> (rvalid_o == $past(rd_i))
   ) else $error("csr_access: rvalid_o does not follow rd_i by one cycle");

endmodule

//--- logic/regbank_top.sv
`timescale 1ns/1ps

module regbank_top #(
   parameter int N = 32  // number of byte registers
) (
   input  logic                             clk_i,
   input  logic                             reset_i,
   input  logic                             cke_i,
   input  logic                             wr_i,
   input  regbank_pkg::wr_req_t             wr_req_i,
   input  logic                             rd_i,
   input  regbank_pkg::rd_req_t             rd_req_i,
   output logic [regbank_pkg::DATA_W-1:0]   rdata_o,
   output logic                             rvalid_o,
   output logic [regbank_pkg::IDX_W-1:0]    last_widx_o
);

   // registered write towards the array
   logic                               wen_q;
   regbank_pkg::wr_req_t               wr_req_q;

   // combinational read between the two blocks
   regbank_pkg::rd_req_t               rd_raddr;
   logic [regbank_pkg::DATA_W-1:0]     rd_word;

   // bus side
   csr_access #(
      .N(N)
   ) i_csr_access (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .wr_i       (wr_i),
      .wr_req_i   (wr_req_i),
      .rd_i       (rd_i),
      .rd_req_i   (rd_req_i),
      .wen_o      (wen_q),
      .wr_req_o   (wr_req_q),
      .rd_req_o   (rd_raddr),
      .rd_word_i  (rd_word),
      .rdata_o    (rdata_o),
      .rvalid_o   (rvalid_o),
      .last_widx_o(last_widx_o)
   );

   // storage, clock enable only reaches here
   regfile_2p #(
      .N(N)
   ) i_regfile_2p (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .cke_i    (cke_i),
      .wen_i    (wen_q),
      .wr_req_i (wr_req_q),
      .rd_req_i (rd_raddr),
      .rd_word_o(rd_word)
   );

endmodule

//--- test/tb_regbank.sv
`timescale 1ns/1ps

module tb_regbank;

   localparam int N = 32;
   localparam int CLK_PERIOD = 8;
   localparam int STRB_W = regbank_pkg::STRB_W;
   localparam int IDX_W = regbank_pkg::IDX_W;

   // cycle budget per phase for the watchdog
   localparam int RESET_CYC = 6;
   localparam int SCAN_CYC = 18;                   // 16 reads plus gap
   localparam int STROBE_CYC = 3 * (8 + 32 + 8 + 1);
   localparam int ORDER_CYC = 3 * 4 + 8 + 2;
   localparam int BOUNDS_CYC = 4 * 10;
   localparam int CKE_CYC = 14;
   localparam int RAND_OPS = 400;
   localparam int DRAIN_CYC = 6;
   localparam int MARGIN_CYC = 200;
   localparam int TOTAL_CYC = RESET_CYC + SCAN_CYC + STROBE_CYC + ORDER_CYC
                            + BOUNDS_CYC + CKE_CYC + RAND_OPS + DRAIN_CYC;

   logic                          clk_i;
   logic                          reset_i;
   logic                          cke_i;
   logic                          wr_i;
   regbank_pkg::wr_req_t          wr_req_i;
   logic                          rd_i;
   regbank_pkg::rd_req_t          rd_req_i;
   logic [regbank_pkg::DATA_W-1:0] rdata_o;
   logic                          rvalid_o;
   logic [IDX_W-1:0]              last_widx_o;

   // reference model state
   logic [7:0]           model_regs [N];
   logic                 pend_wen;     // write seen by the bus stage but not yet in the array
   regbank_pkg::wr_req_t pend_req;
   logic [IDX_W-1:0]     exp_widx;
   logic [31:0]          exp_q [$];    // predicted read words

   logic [31:0] rng = 32'h8a4449e9;
   string       test_name = "reset";
   int          errors = 0;
   int          checks = 0;

   regbank_top #(
      .N(N)
   ) i_regbank_top (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .cke_i      (cke_i),
      .wr_i       (wr_i),
      .wr_req_i   (wr_req_i),
      .rd_i       (rd_i),
      .rd_req_i   (rd_req_i),
      .rdata_o    (rdata_o),
      .rvalid_o   (rvalid_o),
      .last_widx_o(last_widx_o)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   function automatic regbank_pkg::wr_req_t make_wr(input int a, input logic [3:0] strb,
                                                    input logic [31:0] data);
      regbank_pkg::wr_req_t req;
      req.waddr = a[regbank_pkg::WADDR_W-1:0];
      req.wstrb = strb;
      req.wdata = data;
      return req;
   endfunction

   // word address times lanes plus first strobed lane
   function automatic logic [IDX_W-1:0] first_index(input regbank_pkg::wr_req_t req);
      int base;
      base = int'(req.waddr) * STRB_W;
      for (int j = 0; j < STRB_W; j++) begin
         if (req.wstrb[j]) begin
            return IDX_W'(base + j);
         end
      end
      return IDX_W'(base);
   endfunction

   function automatic logic [31:0] model_read(input logic [regbank_pkg::WADDR_W-1:0] a);
      logic [31:0] w;
      int idx;
      w = '0;
      for (int j = 0; j < STRB_W; j++) begin
         idx = int'(a) * STRB_W + j;
         if (idx < N) w[j*8 +: 8] = model_regs[idx];  // past N stays zero
      end
      return w;
   endfunction

   function automatic void model_write(input regbank_pkg::wr_req_t req);
      int idx;
      for (int j = 0; j < STRB_W; j++) begin
         idx = int'(req.waddr) * STRB_W + j;
         if (req.wstrb[j] && idx < N) begin
            model_regs[idx] = req.wdata[j*8 +: 8];
         end
      end
   endfunction

   // model tracks the bank edge by edge with the values the DUT samples
   always @(posedge clk_i) begin
      logic [31:0] exp_word;
      if (reset_i) begin
         foreach (model_regs[i]) model_regs[i] = '0;
         pend_wen = 1'b0;
         exp_widx = '0;
         exp_q.delete();
      end else begin
         if (rvalid_o) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("%s: rvalid_o pulsed with no read outstanding at %0t", test_name, $time);
            end else begin
               exp_word = exp_q.pop_front();
               checks++;
               a_rdata : assert (rdata_o === exp_word)
                  else begin
                     errors++;
                     $display("FAILED %s: rdata_o expected %h, actual %h",
                              test_name, exp_word, rdata_o);
                  end
            end
         end else if (exp_q.size() != 0) begin
            errors++;
            $display("%s: read response missing at %0t", test_name, $time);
            exp_q.delete();
         end
         if (rd_i) exp_q.push_back(model_read(rd_req_i.raddr));  // sees array before this edge
         if (pend_wen && cke_i) model_write(pend_req);
         if (pend_wen && pend_req.wstrb != '0) exp_widx = first_index(pend_req);
         pend_wen = wr_i;
         pend_req = wr_req_i;
      end
   end

   a_rvalid_follows_rd : assert property (
      @(posedge clk_i) disable iff (reset_i)
      1'b1 |=> (rvalid_o == $past(rd_i))
   ) else begin
      errors++;
      $display("%s: rvalid_o did not follow rd_i by exactly one cycle", test_name);
   end

   a_last_widx : assert property (
      @(posedge clk_i) disable iff (reset_i)
      last_widx_o == exp_widx
   ) else begin
      errors++;
      $display("FAILED %s: last_widx_o expected %0d, actual %0d",
               test_name, $sampled(exp_widx), $sampled(last_widx_o));
   end

   // one bus cycle with inputs changed right after the edge
   task automatic drive(input logic wr, input regbank_pkg::wr_req_t wreq,
                        input logic rd, input int raddr);
      @(posedge clk_i);
      wr_i <= wr;
      wr_req_i <= wr ? wreq : '0;
      rd_i <= rd;
      rd_req_i.raddr <= rd ? raddr[regbank_pkg::WADDR_W-1:0] : '0;
   endtask

   task automatic write_word(input int a, input logic [3:0] strb, input logic [31:0] data);
      drive(1'b1, make_wr(a, strb, data), 1'b0, 0);
   endtask

   task automatic read_word(input int a);
      drive(1'b0, '0, 1'b1, a);
   endtask

   task automatic idle(input int n);
      repeat (n) drive(1'b0, '0, 1'b0, 0);
   endtask

   task automatic write_readback(input int a, input logic [3:0] strb, input logic [31:0] data);
      write_word(a, strb, data);
      idle(1);
      read_word(a);  // two cycles after the write sees new data
   endtask

   task automatic set_cke(input logic v);
      @(posedge clk_i);
      cke_i <= v;
      wr_i <= 1'b0;
      rd_i <= 1'b0;
   endtask

   // read in the write cycle then one, two and three cycles later
   task automatic order_probe(input int a, input logic [31:0] data);
      drive(1'b1, make_wr(a, 4'hf, data), 1'b1, a);
      read_word(a);
      read_word(a);
      read_word(a);
   endtask

   task automatic bounds_probe(input int a);
      write_word(a, 4'hf, next_rand());
      idle(1);
      read_word(a);
      read_word(a % (N / STRB_W));  // no aliasing onto the real array
   endtask

   initial begin
      logic [31:0] r;
      clk_i = 1'b0;
      reset_i = 1'b1;
      cke_i = 1'b1;
      wr_i = 1'b0;
      wr_req_i = '0;
      rd_i = 1'b0;
      rd_req_i = '0;
      repeat (4) @(posedge clk_i);
      reset_i <= 1'b0;
      @(negedge clk_i);
      a_reset_outputs : assert (rdata_o == '0 && last_widx_o == '0 && !rvalid_o)
         else begin
            errors++;
            $display("outputs not cleared by reset");
         end

      for (int a = 0; a < 16; a++) read_word(a);
      idle(2);

      test_name = "full word";
      for (int a = 0; a < 8; a++) write_readback(a, 4'hf, next_rand());
      test_name = "byte lanes";
      for (int a = 0; a < 8; a++) begin
         for (int j = 0; j < STRB_W; j++) write_readback(a, 4'(1 << j), next_rand());
      end
      test_name = "mixed strobes";
      for (int a = 0; a < 8; a++) write_readback(a, 4'(next_rand()), next_rand());
      test_name = "zero strobe";
      write_readback(3, 4'h0, next_rand());

      test_name = "ordering";
      order_probe(1, next_rand());
      order_probe(2, next_rand());
      order_probe(5, next_rand());
      for (int a = 0; a < 8; a++) read_word(a);  // back to back
      idle(2);

      test_name = "bounds";
      for (int a = 8; a < 16; a++) bounds_probe(a);
      bounds_probe(62);
      bounds_probe(63);

      test_name = "clock enable";
      set_cke(1'b0);
      for (int a = 0; a < 4; a++) write_word(a, 4'hf, next_rand());
      idle(2);
      set_cke(1'b1);
      for (int a = 0; a < 4; a++) read_word(a);  // still the earlier contents
      idle(2);

      test_name = "random";
      for (int i = 0; i < RAND_OPS; i++) begin
         r = next_rand();
         @(posedge clk_i);
         cke_i <= (r[31:30] != 2'b00);  // enabled about 3 cycles in 4
         wr_i <= r[0];
         rd_i <= r[1];
         wr_req_i <= r[0] ? make_wr(int'(r[7:4]), r[11:8], next_rand()) : '0;
         rd_req_i.raddr <= r[1] ? 6'(r[15:12]) : '0;
      end
      set_cke(1'b1);
      idle(DRAIN_CYC - 1);

      $display("tb_regbank: %0d read checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   initial begin
      #((TOTAL_CYC + MARGIN_CYC) * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, run did not finish",
               TOTAL_CYC + MARGIN_CYC);
      $display("Result: FAILED");
      $finish;
   end

endmodule

//--- list.f
logic/regbank_pkg.sv
logic/strobe_offset.sv
logic/regfile_2p.sv
logic/csr_access.sv
logic/regbank_top.sv
test/tb_regbank.sv

//--- Bender.yml
package:
  name: regbank

sources:
  - files:
      - logic/regbank_pkg.sv
      - logic/strobe_offset.sv
      - logic/regfile_2p.sv
      - logic/csr_access.sv
      - logic/regbank_top.sv
  - target: test
    files:
      - test/tb_regbank.sv
